// File: cam_channel.sv
`include "stitch_config.svh"

module cam_channel import stitch_pkg::*; (
        input  logic        video_clk
    ,   input  logic        rst_n
    ,   cam_link_if.sink    link
    ,   output logic        link_valid
    ,   output pixel_t      link_pixel
    ,   input  logic        link_credit
    ,   output logic        cam_overflow
);

logic       wr_req;
logic       fifo_empty;
logic       fifo_full;
credit_t    credit;         // Free slots in this camera's stitcher queue

assign wr_req = link.clken & link.capture_en;

// ---------------------------------------------------------------------
// Line buffer
// ---------------------------------------------------------------------
sync_fifo #(
        .T          (pixel_t        )
    ,   .DEPTH      (`LINE_DEPTH    )
) u_line_fifo (
        .video_clk  (video_clk              )
    ,   .rst_n      (rst_n                  )
    ,   .push       (wr_req & ~fifo_full    )
    ,   .din        (link.pixel             )
    ,   .pop        (link_valid             )
    ,   .dout       (link_pixel             )
    ,   .empty      (fifo_empty             )
    ,   .full       (fifo_full              )
);

// Send only into guaranteed queue space
assign link_valid = ~fifo_empty & (credit != '0);

// ---------------------------------------------------------------------
// Credit counter and overflow flag
// ---------------------------------------------------------------------
always_ff @(posedge video_clk or negedge rst_n) begin
    if (!rst_n) begin
        credit       <= credit_t'(`CREDITS);
        cam_overflow <= 1'b0;
    end else begin
        case ({link_valid, link_credit})
            2'b10:   credit <= credit - 1'b1;
            2'b01:   credit <= credit + 1'b1;
            default: credit <= credit;     // None, or send and return together
        endcase
        if (wr_req && fifo_full)
            cam_overflow <= 1'b1;           // Camera cannot stall, pixel lost
    end
end

endmodule

// File: cam_frame_sync.sv
`include "stitch_config.svh"

module cam_frame_sync import stitch_pkg::*; (
        input  logic                video_clk
    ,   input  logic                rst_n
    ,   input  logic [`N_CAM-1:0]   cmos_vsync
    ,   input  logic [`N_CAM-1:0]   cmos_clken
    ,   input  pixel_t              cmos_data [`N_CAM]
    ,   cam_link_if.source          links [`N_CAM]
);

logic [`N_CAM-1:0]  vsync_q;
logic [`N_CAM-1:0]  clken_q;
logic [`N_CAM-1:0]  vsync_rise;
logic [`N_CAM-1:0]  armed;          // Camera has shown a frame start
logic               capture_en;
pixel_t             data_q [`N_CAM];

assign vsync_rise = cmos_vsync & ~vsync_q;

always_ff @(posedge video_clk or negedge rst_n) begin
    if (!rst_n) begin
        vsync_q    <= '0;
        clken_q    <= '0;
        armed      <= '0;
        capture_en <= 1'b0;
    end else begin
        vsync_q    <= cmos_vsync;
        clken_q    <= cmos_clken;
        armed      <= armed | vsync_rise;
        // Opens once and stays open
        capture_en <= capture_en | (&(armed | vsync_rise));
    end
end

always_ff @(posedge video_clk) begin
    data_q <= cmos_data;
end

for (genvar i = 0; i < `N_CAM; i++) begin : g_link
    assign links[i].clken      = clken_q[i];
    assign links[i].pixel      = data_q[i];
    assign links[i].capture_en = capture_en;
end

endmodule

// File: cam_link_if.sv
// Registered camera stream from frame sync into one channel
interface cam_link_if (
    input logic video_clk
);

    logic               clken;          // Pixel qualifier
    stitch_pkg::pixel_t pixel;
    logic               capture_en;     // Common to all cameras

    modport source (
        input  video_clk,
        output clken,
        output pixel,
        output capture_en
    );

    modport sink (
        input  video_clk,
        input  clken,
        input  pixel,
        input  capture_en
    );

endinterface

// File: line_stitcher.sv
`include "stitch_config.svh"

module line_stitcher import stitch_pkg::*; (
        input  logic                video_clk
    ,   input  logic                rst_n
    ,   input  logic [`N_CAM-1:0]   link_valid
    ,   input  pixel_t              link_pixel [`N_CAM]
    ,   output logic [`N_CAM-1:0]   link_credit
    ,   input  logic                video_ready
    ,   output logic                video_valid
    ,   output pixel_t              video_data
    ,   output logic                video_sol
    ,   output logic                video_eol
);

localparam int              SW       = $clog2(`SEG_W);
localparam cam_idx_t        LAST_CAM = cam_idx_t'(`N_CAM - 1);
localparam logic [SW-1:0]   LAST_SEG = SW'(`SEG_W - 1);

logic [`N_CAM-1:0]  q_empty;
logic [`N_CAM-1:0]  q_pop;
pixel_t             q_dout [`N_CAM];
cam_idx_t           cur_cam;
logic [SW-1:0]      seg_cnt;        // Position inside current segment
logic               move;
logic               out_empty;
logic               out_full;
video_beat_t        beat_in;
video_beat_t        beat_out;

// ---------------------------------------------------------------------
// Per-camera credit queues
// ---------------------------------------------------------------------
for (genvar i = 0; i < `N_CAM; i++) begin : g_queue
    sync_fifo #(
            .T          (pixel_t    )
        ,   .DEPTH      (`CREDITS   )
    ) u_cam_queue (
            .video_clk  (video_clk      )
        ,   .rst_n      (rst_n          )
        ,   .push       (link_valid[i]  )
        ,   .din        (link_pixel[i]  )
        ,   .pop        (q_pop[i]       )
        ,   .dout       (q_dout[i]      )
        ,   .empty      (q_empty[i]     )
        ,   .full       (               )
    );

    assign q_pop[i] = move && (cur_cam == cam_idx_t'(i));
end

// Wait on the current camera, stop when output queue is full
assign move = ~q_empty[cur_cam] & ~out_full;

assign beat_in.pixel = q_dout[cur_cam];
assign beat_in.sol   = (cur_cam == '0) && (seg_cnt == '0);
assign beat_in.eol   = (cur_cam == LAST_CAM) && (seg_cnt == LAST_SEG);

// ---------------------------------------------------------------------
// Segment round robin
// ---------------------------------------------------------------------
always_ff @(posedge video_clk or negedge rst_n) begin
    if (!rst_n) begin
        cur_cam     <= '0;
        seg_cnt     <= '0;
        link_credit <= '0;
    end else begin
        link_credit <= q_pop;       // One credit back per popped pixel
        if (move) begin
            if (seg_cnt == LAST_SEG) begin
                seg_cnt <= '0;
                cur_cam <= (cur_cam == LAST_CAM) ? '0 : cur_cam + 1'b1;
            end else begin
                seg_cnt <= seg_cnt + 1'b1;
            end
        end
    end
end

// ---------------------------------------------------------------------
// Output queue and video port
// ---------------------------------------------------------------------
sync_fifo #(
        .T          (video_beat_t   )
    ,   .DEPTH      (`OUT_DEPTH     )
) u_out_queue (
        .video_clk  (video_clk                  )
    ,   .rst_n      (rst_n                      )
    ,   .push       (move                       )
    ,   .din        (beat_in                    )
    ,   .pop        (video_valid & video_ready  )
    ,   .dout       (beat_out                   )
    ,   .empty      (out_empty                  )
    ,   .full       (out_full                   )
);

assign video_valid = ~out_empty;
assign video_data  = beat_out.pixel;   // Head entry holds while not accepted
assign video_sol   = beat_out.sol;
assign video_eol   = beat_out.eol;

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module video_stitch_tb -f sim.f -o video_stitch_sim
sim_out=$(./obj_dir/video_stitch_sim +verilator+error+limit+1000)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS"

// File: sim.f
+incdir+.
stitch_pkg.sv
cam_link_if.sv
sync_fifo.sv
cam_frame_sync.sv
cam_channel.sv
line_stitcher.sv
video_stitch_top.sv
tb_clkgen.sv
video_stitch_chk.sv
video_stitch_tb.sv

// File: stitch_config.svh
`ifndef STITCH_CONFIG_SVH
`define STITCH_CONFIG_SVH

// ---------------------------------------------------------------------
// Camera array and pixel format
// ---------------------------------------------------------------------
`define N_CAM       4       // Cameras stitched side by side
`define PIX_W       24      // RGB888
`define SEG_W       8       // Pixels per camera in one output line

// ---------------------------------------------------------------------
// Buffering
// ---------------------------------------------------------------------
`define LINE_DEPTH  16      // Per-camera channel FIFO
`define CREDITS     4       // Stitcher queue depth, also initial credits
`define OUT_DEPTH   8       // Output beat queue

`endif

// File: stitch_pkg.sv
`include "stitch_config.svh"

package stitch_pkg;

    // One camera pixel
    typedef logic [`PIX_W-1:0] pixel_t;

    // Beat on the output video port
    typedef struct packed {
        pixel_t pixel;
        logic   sol;        // First pixel of a stitched line
        logic   eol;        // Last pixel of a stitched line
    } video_beat_t;

    // Selects one camera
    typedef logic [$clog2(`N_CAM)-1:0] cam_idx_t;

    // Holds 0 to CREDITS inclusive
    typedef logic [$clog2(`CREDITS+1)-1:0] credit_t;

endpackage

// File: sync_fifo.sv
module sync_fifo import stitch_pkg::*; #(
        parameter type T     = pixel_t
    ,   parameter int  DEPTH = 4
)(
        input  logic    video_clk
    ,   input  logic    rst_n
    ,   input  logic    push
    ,   input  T        din
    ,   input  logic    pop
    ,   output T        dout
    ,   output logic    empty
    ,   output logic    full
);

localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

T               mem [DEPTH];
logic [AW-1:0]  wr_ptr;
logic [AW-1:0]  rd_ptr;
logic [CW-1:0]  count;
logic           do_push;
logic           do_pop;

assign empty   = (count == '0);
assign full    = (count == CW'(DEPTH));
assign do_push = push & ~full;     // Writes into a full FIFO are lost
assign do_pop  = pop & ~empty;
assign dout    = mem[rd_ptr];      // First word falls through

always_ff @(posedge video_clk) begin
    if (do_push)
        mem[wr_ptr] <= din;
end

always_ff @(posedge video_clk or negedge rst_n) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        if (do_pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

endmodule

// File: tb_clkgen.sv
module tb_clkgen #(
    parameter int PERIOD = 20
)(
    output logic video_clk
);

always begin
    video_clk = 1'b0;
    #(PERIOD / 2);
    video_clk = 1'b1;
    #(PERIOD / 2);
end

endmodule

// File: video_stitch_chk.sv
`include "stitch_config.svh"

module video_stitch_chk import stitch_pkg::*; (
        input  logic                video_clk
    ,   input  logic                rst_n
    ,   input  logic [`N_CAM-1:0]   cmos_clken
    ,   input  pixel_t              cmos_data [`N_CAM]
    ,   input  logic                video_valid
    ,   input  logic                video_ready
    ,   input  pixel_t              video_data
    ,   input  logic                video_sol
    ,   input  logic                video_eol
    ,   input  logic [`N_CAM-1:0]   cam_overflow
);

localparam int LINE_BEATS = `N_CAM * `SEG_W;
localparam int FILL_LIMIT = `LINE_DEPTH + `CREDITS + `OUT_DEPTH + 4;

int unsigned    err_cnt = 0;
int unsigned    beat_k;             // Beats accepted on the video port
int unsigned    sent [`N_CAM];      // Post-sync pixels per camera
int unsigned    taken [`N_CAM];
logic [15:0]    last_seq [`N_CAM];
logic           any_sent;
logic           xfer;
cam_idx_t       exp_cam;
int unsigned    line_pos;

assign xfer     = video_valid & video_ready;
assign exp_cam  = cam_idx_t'((beat_k / `SEG_W) % `N_CAM);
assign line_pos = beat_k % LINE_BEATS;

// ---------------------------------------------------------------------
// Reference counters
// ---------------------------------------------------------------------
always_ff @(posedge video_clk or negedge rst_n) begin
    if (!rst_n) begin
        beat_k   <= 0;
        any_sent <= 1'b0;
        for (int i = 0; i < `N_CAM; i++) begin
            sent[i]     <= 0;
            taken[i]    <= 0;
            last_seq[i] <= '1;      // First beat of a camera then expects 0
        end
    end else begin
        if (xfer) begin
            beat_k            <= beat_k + 1;
            taken[exp_cam]    <= taken[exp_cam] + 1;
            last_seq[exp_cam] <= video_data[15:0];
        end
        for (int i = 0; i < `N_CAM; i++) begin
            if (cmos_clken[i] && !cmos_data[i][19]) begin   // Bit 19 marks pre-sync
                sent[i]  <= sent[i] + 1;
                any_sent <= 1'b1;
            end
        end
    end
end

// ---------------------------------------------------------------------
// Output stream
// ---------------------------------------------------------------------
a_quiet: assert property (@(posedge video_clk) disable iff (!rst_n)
    !any_sent |-> !video_valid && cam_overflow == '0)
    else begin err_cnt++; $error("output active before any captured pixel"); end

a_gate: assert property (@(posedge video_clk) disable iff (!rst_n)
    xfer |-> !video_data[19])
    else begin err_cnt++; $error("error video_data[19] 0x1 expected 0x0"); end

a_cam: assert property (@(posedge video_clk) disable iff (!rst_n)
    xfer |-> video_data[23:20] == {2'b00, exp_cam})
    else begin
        err_cnt++;
        $error("error video_data[23:20] 0x%0h expected 0x%0h", video_data[23:20], exp_cam);
    end

a_seq: assert property (@(posedge video_clk) disable iff (!rst_n)
    xfer |-> video_data[15:0] == last_seq[exp_cam] + 16'd1)
    else begin
        err_cnt++;
        $error("error video_data[15:0] 0x%0h expected 0x%0h",
            video_data[15:0], last_seq[exp_cam] + 16'd1);
    end

a_sol: assert property (@(posedge video_clk) disable iff (!rst_n)
    xfer |-> video_sol == (line_pos == 0))
    else begin
        err_cnt++;
        $error("error video_sol 0x%0h expected 0x%0h", video_sol, line_pos == 0);
    end

a_eol: assert property (@(posedge video_clk) disable iff (!rst_n)
    xfer |-> video_eol == (line_pos == LINE_BEATS - 1))
    else begin
        err_cnt++;
        $error("error video_eol 0x%0h expected 0x%0h", video_eol, line_pos == LINE_BEATS - 1);
    end

// Stalled beat holds until accepted
a_hold: assert property (@(posedge video_clk) disable iff (!rst_n)
    video_valid && !video_ready |=> video_valid && $stable(video_data)
        && $stable(video_sol) && $stable(video_eol))
    else begin err_cnt++; $error("stalled beat changed or was withdrawn"); end

// ---------------------------------------------------------------------
// Overflow flag per camera
// ---------------------------------------------------------------------
for (genvar i = 0; i < `N_CAM; i++) begin : g_cam
    a_ovf_late: assert property (@(posedge video_clk) disable iff (!rst_n)
        $rose(cam_overflow[i]) |-> sent[i] - taken[i] > `LINE_DEPTH)
        else begin err_cnt++; $error("cam_overflow[%0d] rose while buffers had room", i); end

    a_ovf_set: assert property (@(posedge video_clk) disable iff (!rst_n)
        sent[i] - taken[i] >= FILL_LIMIT |-> cam_overflow[i])
        else begin err_cnt++; $error("cam_overflow[%0d] still low after buffers filled", i); end
end

endmodule

// File: video_stitch_tb.sv
`include "stitch_config.svh"

module video_stitch_tb import stitch_pkg::*; ();

localparam int LINES       = 6;
localparam int POST_PIX    = LINES * `SEG_W;                            // Per camera
localparam int HOLD_PIX    = `LINE_DEPTH + `CREDITS + `OUT_DEPTH + 8;    // Ready held low
localparam int PRE_PIX     = 24;
localparam int TOTAL_BEATS = POST_PIX * `N_CAM;
localparam int WATCHDOG    = (PRE_PIX + POST_PIX + HOLD_PIX) * `N_CAM * 20 * 8 + 5000;

logic               video_clk;
logic               rst_n;
logic [`N_CAM-1:0]  cmos_vsync;
logic [`N_CAM-1:0]  cmos_clken;
pixel_t             cmos_data [`N_CAM];
logic               video_valid;
logic               video_ready;
pixel_t             video_data;
logic               video_sol;
logic               video_eol;
logic [`N_CAM-1:0]  cam_overflow;
logic [15:0]        seq [`N_CAM];       // Next sequence number per camera
logic               ready_hold = 1'b0;
int unsigned        beats = 0;

tb_clkgen #(.PERIOD(20)) u_clkgen (.video_clk(video_clk));

video_stitch_top video_stitch_top_inst (.*);

bind video_stitch_top video_stitch_chk chk_inst (.*);

function automatic pixel_t make_pixel(input int cam, input logic pre, input logic [15:0] num);
    return {4'(cam), pre, 3'b000, num};
endfunction

// One cycle of camera activity where pre-sync pixels carry random payload
task automatic drive_cycle(input logic [`N_CAM-1:0] mask, input logic pre);
    @(posedge video_clk);
    for (int i = 0; i < `N_CAM; i++) begin
        cmos_clken[i] <= mask[i];
        if (mask[i] && pre) begin
            cmos_data[i] <= make_pixel(i, 1'b1, 16'($urandom));
        end else if (mask[i]) begin
            cmos_data[i] <= make_pixel(i, 1'b0, seq[i]);
            seq[i] = seq[i] + 1'b1;
        end
    end
endtask

// All cameras in lockstep at no more than one pixel per N_CAM cycles
task automatic pace_slot(input logic go);
    drive_cycle({`N_CAM{go}}, 1'b0);
    repeat (`N_CAM - 1) drive_cycle('0, 1'b0);
endtask

always @(posedge video_clk) begin
    video_ready <= ready_hold ? 1'b0 : ($urandom % 4 != 0);
end

always @(negedge video_clk) begin
    if (video_valid && video_ready)
        beats++;
end

// ---------------------------------------------------------------------
// Stimulus
// ---------------------------------------------------------------------
initial begin
    int          n;
    logic        go;
    int unsigned errs;
    void'($urandom(33));
    rst_n       = 1'b0;
    cmos_vsync  = '0;
    cmos_clken  = '0;
    video_ready = 1'b0;
    for (int i = 0; i < `N_CAM; i++) begin
        cmos_data[i] = '0;
        seq[i]       = '0;
    end
    repeat (16) @(posedge video_clk);
    rst_n <= 1'b1;

    // Staggered frame starts with uncaptured pixels in between
    repeat (PRE_PIX / 2) drive_cycle(`N_CAM'($urandom), 1'b1);
    for (int c = 0; c < `N_CAM; c++) begin
        @(posedge video_clk);
        cmos_vsync[c] <= 1'b1;
        cmos_clken    <= '0;
        if (c < `N_CAM - 1)
            repeat (3) drive_cycle(`N_CAM'($urandom), 1'b1);
    end
    repeat (3) drive_cycle('0, 1'b0);

    n = 0;
    while (n < POST_PIX) begin      // Random ready back-pressure
        go = 1'($urandom);
        pace_slot(go);
        if (go)
            n++;
    end
    wait (beats == TOTAL_BEATS);

    ready_hold = 1'b1;              // Output stalled until the channels overflow
    repeat (HOLD_PIX) pace_slot(1'b1);
    repeat (10) drive_cycle('0, 1'b0);

    errs = video_stitch_top_inst.chk_inst.err_cnt;
    $display("assertion errors: %0d, beats transferred: %0d", errs, beats);
    if (errs == 0)
        $display("TEST RESULT: PASS");
    else
        $display("TEST RESULT: FAIL");
    $finish;
end

initial begin
    #(WATCHDOG);
    $display("watchdog expired before the stimulus completed");
    $display("TEST RESULT: FAIL");
    $finish;
end

endmodule

// File: video_stitch_top.sv
`include "stitch_config.svh"

module video_stitch_top import stitch_pkg::*; (
        input  logic                video_clk
    ,   input  logic                rst_n
    ,   input  logic [`N_CAM-1:0]   cmos_vsync
    ,   input  logic [`N_CAM-1:0]   cmos_clken
    ,   input  pixel_t              cmos_data [`N_CAM]

    // Stitched video stream
    ,   output logic                video_valid
    ,   input  logic                video_ready
    ,   output pixel_t              video_data
    ,   output logic                video_sol
    ,   output logic                video_eol

    ,   output logic [`N_CAM-1:0]   cam_overflow
);

logic [`N_CAM-1:0]  link_valid;
pixel_t             link_pixel [`N_CAM];
logic [`N_CAM-1:0]  link_credit;

cam_link_if links [`N_CAM] (.video_clk(video_clk));

// ---------------------------------------------------------------------
// Input registers and capture gating
// ---------------------------------------------------------------------
cam_frame_sync u_cam_frame_sync (
        .video_clk      (video_clk      )
    ,   .rst_n          (rst_n          )
    ,   .cmos_vsync     (cmos_vsync     )
    ,   .cmos_clken     (cmos_clken     )
    ,   .cmos_data      (cmos_data      )
    ,   .links          (links          )
);

for (genvar i = 0; i < `N_CAM; i++) begin : g_channel
    cam_channel u_cam_channel (
            .video_clk      (video_clk          )
        ,   .rst_n          (rst_n              )
        ,   .link           (links[i]           )
        ,   .link_valid     (link_valid[i]      )
        ,   .link_pixel     (link_pixel[i]      )
        ,   .link_credit    (link_credit[i]     )
        ,   .cam_overflow   (cam_overflow[i]    )
    );
end

line_stitcher u_line_stitcher (
        .video_clk      (video_clk      )
    ,   .rst_n          (rst_n          )
    ,   .link_valid     (link_valid     )
    ,   .link_pixel     (link_pixel     )
    ,   .link_credit    (link_credit    )
    ,   .video_ready    (video_ready    )
    ,   .video_valid    (video_valid    )
    ,   .video_data     (video_data     )
    ,   .video_sol      (video_sol      )
    ,   .video_eol      (video_eol      )
);

endmodule
